/* test/cpu_trace.txt */
# Columns: tag, hex value. P program word (loaded from 100 hex on), K key input,
# L expected ledr, H expected hex. First H and L are the values right after reset.
P 80000501  # 100 ADDI r1, r0, 5
P 80000302  # 104 ADDI r2, r0, 3
P 00800312  # 108 ADD  r3, r1, r2
P 00A00432  # 10C SUB  r4, r3, r2
P 00C40542  # 110 LSHF r5, r4, r2
P 9803C356  # 114 XORI r6, r5, 3C3
P 68F02006  # 118 SW   r6 to ledr
P 80FFF007  # 11C ADDI r7, r0, -16
P 00C00872  # 120 RSHF r8, r7, r2
P 00B00983  # 124 NAND r9, r8, r3
P 907ABC9A  # 128 ANDI r10, r9, 7ABC
P 944001AB  # 12C ORI  r11, r10, 4001
P 68F0000B  # 130 SW   r11 to hex
P 68004009  # 134 SW   r9 to mem 40
P 4800400C  # 138 LW   r12 from mem 40
P 68F0000C  # 13C SW   r12 to hex
P 8003C00E  # 140 ADDI r14, r0, 3C0 (wrong path marker)
P 20000112  # 144 BEQ  r1, r2 not taken
P 68F02001  # 148 SW   r1 to ledr
P 20000114  # 14C BEQ  r1, r4 taken
P 68F0200E  # 150 SW   r14 to ledr, skipped
P 24000112  # 154 BLT  r1, r2 not taken
P 68F02003  # 158 SW   r3 to ledr
P 24000171  # 15C BLT  r7, r1 taken, signed
P 68F0200E  # 160 SW   r14 to ledr, skipped
P 28000131  # 164 BLE  r3, r1 not taken
P 68F02005  # 168 SW   r5 to ledr
P 28000114  # 16C BLE  r1, r4 taken
P 68F0200E  # 170 SW   r14 to ledr, skipped
P 2C000114  # 174 BNE  r1, r4 not taken
P 68F02002  # 178 SW   r2 to ledr
P 2C000112  # 17C BNE  r1, r2 taken
P 68F0200E  # 180 SW   r14 to ledr, skipped
P 3000640F  # 184 JAL  r15, 190
P 68F0000E  # 188 SW   r14 to hex, flushed
P 68F0200E  # 18C SW   r14 to ledr, flushed
P 68F0000F  # 190 SW   r15 to hex
P 48F0800D  # 194 LW   r13 from key
P 68F0200D  # 198 SW   r13 to ledr
P 20FFFF00  # 19C BEQ  r0, r0 to itself
P 00000000
P 00000000
K 9
H FEDEAD
L 000
L 3EB
H 007AB5
H FFFFF7
L 005
L 008
L 028
L 003
H 000188
L 006

/* compile.f */
common/cpu_pkg.sv
hdl/fetch_unit.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
result/result_stage.sv
hdl/cpu_top.sv
test/tb_cpu.sv

/* test/tb_cpu.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_cpu;
    import cpu_pkg::*;

    localparam int    clk_half     = 4;
    localparam word_t load_base    = 32'h0000_0040;   // start_pc 100 hex as a word index
    localparam int    reset_cycles = 5;
    localparam int    wait_cycles  = 200;

    logic        clk;
    logic        reset;
    logic [3:0]  key;
    imem_load_t  imem_load;
    logic [23:0] hex;
    logic [9:0]  ledr;

    word_t       prog_words [$];
    logic [7:0]  ev_tag [$];
    word_t       ev_val [$];

    // Output values in the order they appeared
    logic [23:0] hex_seen [$];
    logic [9:0]  ledr_seen [$];
    logic [23:0] hex_prev;
    logic [9:0]  ledr_prev;
    logic        watching;
    logic        primed;

    int          tests;
    int          errors;
    logic        aborted;

    cpu_top dut (
        .clk       (clk),
        .reset     (reset),
        .key       (key),
        .imem_load (imem_load),
        .hex       (hex),
        .ledr      (ledr)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    // Sample mid-cycle since outputs move on the rising edge
    always @(negedge clk) begin
        if (watching) begin
            if (!primed || hex !== hex_prev) hex_seen.push_back(hex);
            if (!primed || ledr !== ledr_prev) ledr_seen.push_back(ledr);
            hex_prev  = hex;
            ledr_prev = ledr;
            primed    = 1'b1;
        end
    end

    task automatic read_trace;
        int         fd;
        int         n;
        string      line;
        logic [7:0] tag;
        word_t      value;
        fd = $fopen("test/cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file test/cpu_trace.txt");
            errors++;
            aborted = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%c %h", tag, value) == 2) begin
                    if (tag == "P") prog_words.push_back(value);
                    else begin
                        ev_tag.push_back(tag);
                        ev_val.push_back(value);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    // Reset spans the program load plus five idle cycles
    task automatic load_program;
        for (int i = 0; i < prog_words.size(); i++) begin
            @(posedge clk);
            imem_load <= '{we: 1'b1, addr: load_base + word_t'(i), data: prog_words[i]};
        end
        @(posedge clk);
        imem_load <= '0;
        repeat (reset_cycles) @(posedge clk);
        reset    <= 1'b0;
        watching <= 1'b1;
    endtask

    task automatic drive_key(input logic [3:0] value);
        @(posedge clk);
        key <= value;
    endtask

    task automatic wait_ledr(output logic [9:0] got, output logic ok);
        int n;
        n = 0;
        while (ledr_seen.size() == 0 && n < wait_cycles) begin
            @(posedge clk);
            n++;
        end
        ok  = ledr_seen.size() != 0;
        got = ok ? ledr_seen.pop_front() : '0;
    endtask

    task automatic wait_hex(output logic [23:0] got, output logic ok);
        int n;
        n = 0;
        while (hex_seen.size() == 0 && n < wait_cycles) begin
            @(posedge clk);
            n++;
        end
        ok  = hex_seen.size() != 0;
        got = ok ? hex_seen.pop_front() : '0;
    endtask

    task automatic check_ledr(input logic [9:0] expected, input logic [9:0] actual);
        tests++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ledr got %03h expected %03h", $time, actual, expected);
        end else begin
            $display("[PASS] %0t ledr %03h", $time, actual);
        end
    endtask

    task automatic check_hex(input logic [23:0] expected, input logic [23:0] actual);
        tests++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t hex got %06h expected %06h", $time, actual, expected);
        end else begin
            $display("[PASS] %0t hex %06h", $time, actual);
        end
    endtask

    task automatic run_events;
        logic [9:0]  got_ledr;
        logic [23:0] got_hex;
        logic        ok;
        for (int i = 0; i < ev_tag.size() && !aborted; i++) begin
            case (ev_tag[i])
                "K": drive_key(ev_val[i][3:0]);
                "L": begin
                    wait_ledr(got_ledr, ok);
                    if (ok) check_ledr(ev_val[i][9:0], got_ledr);
                    else begin
                        $display("Timeout at %0t: ledr never changed to %03h",
                                 $time, ev_val[i][9:0]);
                        errors++;
                        aborted = 1'b1;
                    end
                end
                "H": begin
                    wait_hex(got_hex, ok);
                    if (ok) check_hex(ev_val[i][23:0], got_hex);
                    else begin
                        $display("Timeout at %0t: hex never changed to %06h",
                                 $time, ev_val[i][23:0]);
                        errors++;
                        aborted = 1'b1;
                    end
                end
                default: begin
                    $display("Unknown tag %c in the trace file", ev_tag[i]);
                    errors++;
                end
            endcase
        end
    endtask

    initial begin
        $timeformat(-9, 0, " ns", 0);
        reset     = 1'b1;
        key       = 4'h0;
        imem_load = '0;
        watching  = 1'b0;
        primed    = 1'b0;
        hex_prev  = '0;
        ledr_prev = '0;
        tests     = 0;
        errors    = 0;
        aborted   = 1'b0;
        read_trace();
        if (!aborted) begin
            load_program();
            run_events();
        end
        $display("%0d checks run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/cpu_top.sv */
`default_nettype none
`timescale 1ns/100ps

module cpu_top #(
    parameter cpu_pkg::word_t start_pc       = 32'h0000_0100,
    parameter int             imem_addr_bits = 12,
    parameter int             dmem_addr_bits = 12
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire [3:0]                key,
    input  wire cpu_pkg::imem_load_t imem_load,
    output logic [23:0]              hex,
    output logic [9:0]               ledr
);
    import cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    redirect_t redirect;
    wb_t       wb;
    logic      stall;

    fetch_unit #(
        .start_pc       (start_pc),
        .imem_addr_bits (imem_addr_bits)
    ) u_fetch (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .imem_load (imem_load),
        .if_id     (if_id)
    );

    // Needs ex_mem too, for the hazard check
    decode_stage u_decode (
        .clk      (clk),
        .reset    (reset),
        .if_id    (if_id),
        .redirect (redirect),
        .ex_mem   (ex_mem),
        .wb       (wb),
        .stall    (stall),
        .id_ex    (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset    (reset),
        .id_ex    (id_ex),
        .redirect (redirect),
        .ex_mem   (ex_mem)
    );

    result_stage #(
        .dmem_addr_bits (dmem_addr_bits)
    ) u_result (
        .clk    (clk),
        .reset  (reset),
        .ex_mem (ex_mem),
        .key    (key),
        .wb     (wb),
        .hex    (hex),
        .ledr   (ledr)
    );

endmodule

`default_nettype wire

/* result/result_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module result_stage #(
    parameter int dmem_addr_bits = 12
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire cpu_pkg::ex_mem_t ex_mem,
    input  wire [3:0]             key,
    output cpu_pkg::wb_t          wb,
    output logic [23:0]           hex,
    output logic [9:0]            ledr
);
    import cpu_pkg::*;

    localparam int dmem_words = 1 << dmem_addr_bits;

    word_t addr;
    logic  is_hex;
    logic  is_ledr;
    logic  is_key;
    logic  is_io;
    word_t load_data;
    word_t wb_data;

    word_t dmem [0:dmem_words-1];

    assign addr    = ex_mem.alu_out;
    assign is_hex  = addr == addr_hex;
    assign is_ledr = addr == addr_ledr;
    assign is_key  = addr == addr_key;
    assign is_io   = is_hex || is_ledr || is_key;

    always_ff @(posedge clk) begin
        if (ex_mem.ctrl.mem_write && !is_io) begin
            dmem[addr[dmem_addr_bits+1:2]] <= ex_mem.store_data;
        end
    end

    // Output registers
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hex  <= hex_reset;
            ledr <= '0;
        end else if (ex_mem.ctrl.mem_write) begin
            if (is_hex) hex <= ex_mem.store_data[23:0];
            if (is_ledr) ledr <= ex_mem.store_data[9:0];
        end
    end

    // Keys are active low on the board
    assign load_data = (ex_mem.ctrl.mem_read && is_key) ? {28'b0, ~key}
                                                        : dmem[addr[dmem_addr_bits+1:2]];

    always_comb begin
        case (ex_mem.ctrl.wb_sel)
            wb_pc:   wb_data = ex_mem.pc_plus;
            wb_mem:  wb_data = load_data;
            default: wb_data = ex_mem.alu_out;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb <= '0;
        end else begin
            wb.we   <= ex_mem.ctrl.reg_write;
            wb.dst  <= ex_mem.dst;
            wb.data <= wb_data;
        end
    end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module execute_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::redirect_t      redirect,
    output cpu_pkg::ex_mem_t        ex_mem
);
    import cpu_pkg::*;

    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    word_t imm_x4;
    logic  br_cond;

    assign alu_a  = id_ex.rs_val;
    assign alu_b  = id_ex.ctrl.alu_imm ? id_ex.imm : id_ex.rt_val;
    assign imm_x4 = {id_ex.imm[29:0], 2'b00};       // Word offset to bytes

    always_comb begin
        case (id_ex.op1)
            op1_alur: begin
                case (id_ex.op2)
                    op2_eq:   alu_out = {31'b0, alu_a == alu_b};
                    op2_lt:   alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
                    op2_le:   alu_out = {31'b0, $signed(alu_a) <= $signed(alu_b)};
                    op2_ne:   alu_out = {31'b0, alu_a != alu_b};
                    op2_add:  alu_out = alu_a + alu_b;
                    op2_sub:  alu_out = alu_a - alu_b;
                    op2_and:  alu_out = alu_a & alu_b;
                    op2_or:   alu_out = alu_a | alu_b;
                    op2_xor:  alu_out = alu_a ^ alu_b;
                    op2_nand: alu_out = ~(alu_a & alu_b);
                    op2_nor:  alu_out = ~(alu_a | alu_b);
                    op2_xnor: alu_out = ~(alu_a ^ alu_b);
                    op2_rshf: alu_out = $signed(alu_a) >>> alu_b;   // Arithmetic
                    op2_lshf: alu_out = alu_a << alu_b;
                    default:  alu_out = '0;
                endcase
            end
            op1_addi, op1_lw, op1_sw: alu_out = alu_a + alu_b;  // Also the address
            op1_andi: alu_out = alu_a & alu_b;
            op1_ori:  alu_out = alu_a | alu_b;
            op1_xori: alu_out = alu_a ^ alu_b;
            default:  alu_out = '0;
        endcase
    end

    // Signed compare of the two register operands
    always_comb begin
        case (id_ex.op1)
            op1_beq: br_cond = id_ex.rs_val == id_ex.rt_val;
            op1_blt: br_cond = $signed(id_ex.rs_val) < $signed(id_ex.rt_val);
            op1_ble: br_cond = $signed(id_ex.rs_val) <= $signed(id_ex.rt_val);
            op1_bne: br_cond = id_ex.rs_val != id_ex.rt_val;
            default: br_cond = 1'b0;
        endcase
    end

    always_comb begin
        redirect.valid = (id_ex.ctrl.is_branch && br_cond) || id_ex.ctrl.is_jal;
        if (id_ex.ctrl.is_jal) begin
            redirect.target = id_ex.rs_val + imm_x4;
        end else begin
            redirect.target = id_ex.pc_plus + imm_x4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_mem <= '0;
        end else begin
            ex_mem.ctrl       <= id_ex.ctrl;
            ex_mem.alu_out    <= alu_out;
            ex_mem.store_data <= id_ex.rt_val;
            ex_mem.pc_plus    <= id_ex.pc_plus;     // JAL link value
            ex_mem.dst        <= id_ex.dst;
        end
    end

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`default_nettype none
`timescale 1ns/100ps

module decode_stage (
    input  wire                     clk,
    input  wire                     reset,
    input  wire cpu_pkg::if_id_t    if_id,
    input  wire cpu_pkg::redirect_t redirect,
    input  wire cpu_pkg::ex_mem_t   ex_mem,
    input  wire cpu_pkg::wb_t       wb,
    output logic                    stall,
    output cpu_pkg::id_ex_t         id_ex
);
    import cpu_pkg::*;

    inst_u    inst;
    op1_e     op1;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dst;
    word_t    rs_val;
    word_t    rt_val;
    word_t    imm_sx;
    ctrl_t    ctrl;
    logic     rt_used;

    assign inst   = if_id.inst;
    assign op1    = inst.r.op1;
    assign rs     = inst.r.rs;
    assign rt     = inst.r.rt;
    assign imm_sx = {{16{inst.i.imm[15]}}, inst.i.imm};
    assign dst    = (op1 == op1_alur) ? inst.r.rd : rt;    // rt for I-type and JAL link

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs     (rs),
        .rt     (rt),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .wb     (wb)
    );

    always_comb begin
        ctrl = '0;
        if (inst != '0) begin       // Zero word is a bubble
            case (op1)
                op1_alur: begin
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_alu;
                end
                op1_addi, op1_andi, op1_ori, op1_xori: begin
                    ctrl.alu_imm   = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_alu;
                end
                op1_lw: begin
                    ctrl.alu_imm   = 1'b1;
                    ctrl.mem_read  = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_mem;
                end
                op1_sw: begin
                    ctrl.alu_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                end
                op1_beq, op1_blt, op1_ble, op1_bne: ctrl.is_branch = 1'b1;
                op1_jal: begin
                    ctrl.is_jal    = 1'b1;
                    ctrl.reg_write = 1'b1;
                    ctrl.wb_sel    = wb_pc;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // Source still owed by an older instruction
    function automatic logic pending(input reg_idx_t src);
        pending = (src != '0) &&
                  ((id_ex.ctrl.reg_write  && (id_ex.dst  == src)) ||
                   (ex_mem.ctrl.reg_write && (ex_mem.dst == src)) ||
                   (wb.we                 && (wb.dst     == src)));
    endfunction

    always_comb begin
        rt_used = op1 inside {op1_alur, op1_beq, op1_blt, op1_ble, op1_bne, op1_sw};
        stall   = pending(rs) || (rt_used && pending(rt));
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex <= '0;
        end else if (redirect.valid || stall) begin
            id_ex <= '0;
        end else begin
            id_ex.ctrl    <= ctrl;
            id_ex.op1     <= op1;
            id_ex.op2     <= inst.r.op2;
            id_ex.pc_plus <= if_id.pc_plus;
            id_ex.rs_val  <= rs_val;
            id_ex.rt_val  <= rt_val;
            id_ex.imm     <= imm_sx;
            id_ex.dst     <= dst;
        end
    end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`default_nettype none
`timescale 1ns/100ps

module reg_file (
    input  wire                    clk,
    input  wire                    reset,
    input  wire cpu_pkg::reg_idx_t rs,
    input  wire cpu_pkg::reg_idx_t rt,
    output cpu_pkg::word_t         rs_val,
    output cpu_pkg::word_t         rt_val,
    input  wire cpu_pkg::wb_t      wb
);
    import cpu_pkg::*;

    word_t regs [0:15];

    assign rs_val = regs[rs];
    assign rt_val = regs[rt];

    // Falling edge write so decode sees it before the next rising edge
    always_ff @(negedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.dst != '0)) begin    // r0 stays zero
            regs[wb.dst] <= wb.data;
        end
    end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
`default_nettype none
`timescale 1ns/100ps

module fetch_unit #(
    parameter cpu_pkg::word_t start_pc       = 32'h0000_0100,
    parameter int             imem_addr_bits = 12
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      stall,
    input  wire cpu_pkg::redirect_t  redirect,
    input  wire cpu_pkg::imem_load_t imem_load,
    output cpu_pkg::if_id_t          if_id
);
    import cpu_pkg::*;

    localparam int imem_words = 1 << imem_addr_bits;

    word_t pc;
    word_t pc_plus;
    word_t pc_next;
    word_t fetch_word;

    word_t imem [0:imem_words-1];

    assign pc_plus = pc + 32'd4;

    // Byte PC to word index
    assign fetch_word = imem[pc[imem_addr_bits+1:2]];

    // Program load, meant for while reset is held
    always_ff @(posedge clk) begin
        if (imem_load.we) begin
            imem[imem_load.addr[imem_addr_bits-1:0]] <= imem_load.data;
        end
    end

    // Redirect beats stall, otherwise predict not taken
    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= start_pc;
        end else begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            if_id <= '0;
        end else if (redirect.valid) begin
            if_id <= '0;                    // Drop wrong-path word
        end else if (!stall) begin
            if_id.pc_plus <= pc_plus;
            if_id.inst    <= fetch_word;
        end
    end

endmodule

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_idx_t;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        op1_alur = 6'b000000,
        op1_beq  = 6'b001000,
        op1_blt  = 6'b001001,
        op1_ble  = 6'b001010,
        op1_bne  = 6'b001011,
        op1_jal  = 6'b001100,
        op1_lw   = 6'b010010,
        op1_sw   = 6'b011010,
        op1_addi = 6'b100000,
        op1_andi = 6'b100100,
        op1_ori  = 6'b100101,
        op1_xori = 6'b100110
    } op1_e;

    // ALU function for op1_alur, bits 25:18
    typedef enum logic [7:0] {
        op2_eq   = 8'b00001000,
        op2_lt   = 8'b00001001,
        op2_le   = 8'b00001010,
        op2_ne   = 8'b00001011,
        op2_add  = 8'b00100000,
        op2_and  = 8'b00100100,
        op2_or   = 8'b00100101,
        op2_xor  = 8'b00100110,
        op2_sub  = 8'b00101000,
        op2_nand = 8'b00101100,
        op2_nor  = 8'b00101101,
        op2_xnor = 8'b00101110,
        op2_rshf = 8'b00110000,
        op2_lshf = 8'b00110001
    } op2_e;

    typedef struct packed {
        op1_e       op1;
        op2_e       op2;
        logic [5:0] spare;
        reg_idx_t   rd;
        reg_idx_t   rs;
        reg_idx_t   rt;
    } inst_r_t;

    typedef struct packed {
        op1_e        op1;
        logic [1:0]  spare;
        logic [15:0] imm;   // Sits over op2 and rd
        reg_idx_t    rs;
        reg_idx_t    rt;
    } inst_i_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

    typedef enum logic [1:0] {
        wb_pc  = 2'b00,     // Link value
        wb_mem = 2'b01,
        wb_alu = 2'b10
    } wb_sel_e;

    typedef struct packed {
        logic    alu_imm;
        logic    is_branch;
        logic    is_jal;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_sel_e wb_sel;
    } ctrl_t;

    typedef struct packed {
        word_t pc_plus;
        inst_u inst;
    } if_id_t;

    typedef struct packed {
        ctrl_t    ctrl;
        op1_e     op1;
        op2_e     op2;
        word_t    pc_plus;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;      // Sign extended
        reg_idx_t dst;
    } id_ex_t;

    typedef struct packed {
        ctrl_t    ctrl;
        word_t    alu_out;
        word_t    store_data;
        word_t    pc_plus;
        reg_idx_t dst;
    } ex_mem_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    typedef struct packed {
        logic     we;
        reg_idx_t dst;
        word_t    data;
    } wb_t;

    typedef struct packed {
        logic  we;
        word_t addr;        // Word index, not byte address
        word_t data;
    } imem_load_t;

    localparam word_t       addr_hex  = 32'hFFFF_F000;
    localparam word_t       addr_ledr = 32'hFFFF_F020;
    localparam word_t       addr_key  = 32'hFFFF_F080;
    localparam logic [23:0] hex_reset = 24'hFEDEAD;

endpackage

`default_nettype wire
